//--- tb.f
+incdir+.
core_pkg.sv
sp_ram.sv
phase_timer.sv
bus_responder.sv
ctrl_regs.sv
load_port.sv
core_top.sv
tb_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_core
FILELIST  = tb.f

SRCS = core_defs.svh core_pkg.sv sp_ram.sv phase_timer.sv bus_responder.sv \
       ctrl_regs.sv load_port.sv core_top.sv tb_util.svh tb_core.sv
BIN      = obj_dir/V$(TOP)
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_util.svh
/*
 * testbench helpers for the host control block
 * random source, cpu bus and target port access, typed compares
 */

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// xorshift32, advances the shared generator state
function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

//////////////////////////////////////////////////
// bus access
//////////////////////////////////////////////////

// one access, strobe zero reads; lat counts clock edges up to ready
task automatic bus_access(input cpu_addr_t addr, input cpu_word_t wdata, input wstrb_t strb,
                          output cpu_word_t rdata, output int lat, output logic ph1_before);
  int   n;
  logic seen;
  n          = 0;
  seen       = 1'b0;
  ph1_before = 1'b0;
  rdata      = '0;
  @(posedge clk_8mhz);
  cpu_valid <= 1'b1;
  cpu_addr  <= addr;
  cpu_wdata <= wdata;
  cpu_wstrb <= strb;
  while (!seen && n < BUS_WAIT_MAX) begin
    @(posedge clk_8mhz);
    n++;
    @(negedge clk_8mhz);
    if (cpu_ready) begin
      seen  = 1'b1;
      rdata = cpu_rdata;
    end else begin
      ph1_before = ph1_en;
    end
  end
  if (!seen) begin
    errors++;
    $display("no ready from the bus within %0d cycles at %0t ns, address %h",
             BUS_WAIT_MAX, $time, addr);
  end
  lat = n;
  // valid drops for at least one cycle before the next access
  @(posedge clk_8mhz);
  cpu_valid <= 1'b0;
  cpu_wstrb <= '0;
endtask

// registered read, data one cycle after the address
task automatic read_target(input tgt_addr_t addr, output byte_t data);
  @(posedge clk_8mhz);
  tgt_addr <= addr;
  @(posedge clk_8mhz);
  @(negedge clk_8mhz);
  data = tgt_rdata;
endtask

//////////////////////////////////////////////////
// compares
//////////////////////////////////////////////////
task automatic compare_word(input cpu_word_t got, input cpu_word_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_joy(input joy_t got, input joy_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
  end
endtask

`endif

//--- tb_core.sv
/*
 * testbench for the host control block
 * plays the embedded cpu on the memory bus and the target on the
 * main ram port, runs directed tests under a cycle watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module tb_core import core_pkg::*; ();

  localparam int CLK_HALF        = 2;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 400;
  localparam int BUS_WAIT_MAX    = 64;
  localparam int N_WRAM          = 16;
  localparam int N_LOAD          = 20;

  logic        clk_8mhz = 1'b0;
  logic        rst;
  logic        cpu_valid;
  cpu_addr_t   cpu_addr;
  cpu_word_t   cpu_wdata;
  wstrb_t      cpu_wstrb;
  logic        cpu_ready;
  cpu_word_t   cpu_rdata;
  tgt_addr_t   tgt_addr;
  byte_t       tgt_wdata;
  logic        tgt_we;
  byte_t       tgt_rdata;
  key_t        cont1_key;
  key_t        cont2_key;
  key_t        cont3_key;
  key_t        cont4_key;
  joy_t        joy1;
  joy_t        joy2;
  logic [1:0]  osd_ctrl;
  logic [63:0] kbd_mask;
  logic        target_rst;
  logic        ph1_en;
  logic        ph2_en;

  int          errors;
  int          checks;
  int          tests_run;
  logic [31:0] rng_state;

  `include "tb_util.svh"

  always #CLK_HALF clk_8mhz = ~clk_8mhz;

  core_top uut (
    .clk_8mhz       (clk_8mhz),
    .rst            (rst),
    .i_cpu_valid    (cpu_valid),
    .i_cpu_addr     (cpu_addr),
    .i_cpu_wdata    (cpu_wdata),
    .i_cpu_wstrb    (cpu_wstrb),
    .o_cpu_ready    (cpu_ready),
    .o_cpu_rdata    (cpu_rdata),
    .i_tgt_addr     (tgt_addr),
    .i_tgt_wdata    (tgt_wdata),
    .i_tgt_we       (tgt_we),
    .o_tgt_rdata    (tgt_rdata),
    .i_cont1_key    (cont1_key),
    .i_cont2_key    (cont2_key),
    .i_cont3_key    (cont3_key),
    .i_cont4_key    (cont4_key),
    .o_joy1         (joy1),
    .o_joy2         (joy2),
    .o_osd_ctrl     (osd_ctrl),
    .o_keyboard_mask(kbd_mask),
    .o_target_rst   (target_rst),
    .o_ph1_en       (ph1_en),
    .o_ph2_en       (ph2_en)
  );

  // select 1 takes controller 1, select 2 controller 2, anything else idles
  function automatic joy_t expected_joy(input logic [1:0] sel, input key_t k1, input key_t k2);
    joy_t j;
    j = '0;
    if (sel == 2'd1) begin
      j = k1[6:0];
    end else if (sel == 2'd2) begin
      j = k2[6:0];
    end
    return j;
  endfunction

  function automatic cpu_addr_t wram_addr(input logic [9:0] idx);
    return {`REGION_WRAM_NIB, 16'h0000, idx, 2'b00};
  endfunction

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  // steps whole cycles until the chosen phase enable is seen
  task automatic wait_pulse(input logic want_ph2, output int n);
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 32) begin
      @(negedge clk_8mhz);
      n++;
      seen = want_ph2 ? ph2_en : ph1_en;
    end
    if (!seen) begin
      errors++;
      $display("no phase enable pulse within 32 cycles at %0t ns", $time);
    end
  endtask

  task automatic check_load_timing(input int lat, input logic p1);
    checks++;
    if (lat < 5 || lat > 13) begin
      errors++;
      $display("mismatch at %0t ns: load ready latency %0d expected 5 to 13", $time, lat);
    end
    checks++;
    if (p1 !== 1'b1) begin
      errors++;
      $display("load ready at %0t ns did not follow a phase-1 enable", $time);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    int        e0;
    int        lat;
    logic      p1;
    cpu_word_t rd;
    e0 = errors;
    @(negedge clk_8mhz);
    compare_bit(cpu_ready, 1'b0, "ready after reset");
    compare_bit(target_rst, 1'b1, "target reset after reset");
    compare_bit(ph1_en, 1'b1, "ph1 in the first cycle after reset");
    compare_word(kbd_mask[31:0], '0, "keyboard mask low after reset");
    compare_word(kbd_mask[63:32], '0, "keyboard mask high after reset");
    compare_word({30'h0, osd_ctrl}, '0, "osd control after reset");
    compare_joy(joy1, '0, "joystick 1 after reset");
    compare_joy(joy2, '0, "joystick 2 after reset");
    bus_access(`REG_EMU_CTRL, '0, 4'b0000, rd, lat, p1);
    compare_word(rd, '0, "emulator control after reset");
    finish_test("reset", e0);
  endtask

  task automatic test_registers();
    int        e0;
    int        lat;
    logic      p1;
    key_t      keys [4];
    cpu_word_t osd_w;
    cpu_word_t lo_w;
    cpu_word_t hi_w;
    cpu_word_t emu_w;
    cpu_word_t rd;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      rd      = next_random();
      keys[i] = rd[15:0];
    end
    @(posedge clk_8mhz);
    cont1_key <= keys[0];
    cont2_key <= keys[1];
    cont3_key <= keys[2];
    cont4_key <= keys[3];
    osd_w = next_random();
    lo_w  = next_random();
    hi_w  = next_random();
    emu_w = next_random();
    bus_access(`REG_OSD_CTRL, osd_w, 4'b1111, rd, lat, p1);
    bus_access(`REG_KBD_MASK_LO, lo_w, 4'b1111, rd, lat, p1);
    bus_access(`REG_KBD_MASK_HI, hi_w, 4'b1111, rd, lat, p1);
    bus_access(`REG_EMU_CTRL, emu_w, 4'b1111, rd, lat, p1);
    // key words are read only
    rd = next_random();
    bus_access(`REG_CONT2_KEY, rd, 4'b1111, rd, lat, p1);
    bus_access(`REG_EMU_CTRL, '0, 4'b0000, rd, lat, p1);
    compare_word(rd, {25'h0, emu_w[6:0]}, "emulator control readback");
    for (int i = 0; i < 4; i++) begin
      bus_access(`REG_CONT1_KEY + (32'(i) << 2), '0, 4'b0000, rd, lat, p1);
      compare_word(rd, {16'h0000, keys[i]}, "controller key readback");
    end
    @(negedge clk_8mhz);
    compare_word(kbd_mask[31:0], lo_w, "keyboard mask low");
    compare_word(kbd_mask[63:32], hi_w, "keyboard mask high");
    compare_word({30'h0, osd_ctrl}, {30'h0, osd_w[1:0]}, "osd control");
    // every select pair with the run bit kept low
    for (int s1 = 0; s1 < 4; s1++) begin
      for (int s2 = 0; s2 < 4; s2++) begin
        emu_w = {27'h0, 2'(s2), 2'(s1), 1'b0};
        bus_access(`REG_EMU_CTRL, emu_w, 4'b1111, rd, lat, p1);
        @(negedge clk_8mhz);
        compare_joy(joy1, expected_joy(2'(s1), keys[0], keys[1]), "joystick 1");
        compare_joy(joy2, expected_joy(2'(s2), keys[0], keys[1]), "joystick 2");
      end
    end
    finish_test("registers", e0);
  endtask

  task automatic test_work_ram();
    int          e0;
    int          lat;
    logic        p1;
    cpu_word_t   model [0:1023];
    logic        used [0:1023];
    logic [9:0]  idx_q [$];
    logic [9:0]  idx;
    logic [1:0]  lane;
    logic [31:0] r;
    cpu_word_t   wdata;
    cpu_word_t   rd;
    e0 = errors;
    for (int i = 0; i < 1024; i++) begin
      used[i] = 1'b0;
    end
    for (int i = 0; i < N_WRAM; i++) begin
      r     = next_random();
      idx   = r[9:0];
      wdata = next_random();
      bus_access(wram_addr(idx), wdata, 4'b1111, rd, lat, p1);
      compare_word(32'(lat), 32'd1, "work ram write latency");
      model[idx] = wdata;
      if (!used[idx]) begin
        used[idx] = 1'b1;
        idx_q.push_back(idx);
      end
    end
    // single lanes over words already written
    for (int i = 0; i < N_WRAM; i++) begin
      r     = next_random();
      idx   = idx_q[r[15:0] % idx_q.size()];
      lane  = r[17:16];
      wdata = next_random();
      bus_access(wram_addr(idx), wdata, 4'b0001 << lane, rd, lat, p1);
      compare_word(32'(lat), 32'd1, "work ram lane write latency");
      model[idx][lane*8 +: 8] = wdata[lane*8 +: 8];
    end
    foreach (idx_q[k]) begin
      bus_access(wram_addr(idx_q[k]), '0, 4'b0000, rd, lat, p1);
      compare_word(32'(lat), 32'd1, "work ram read latency");
      compare_word(rd, model[idx_q[k]], "work ram readback");
    end
    finish_test("work ram", e0);
  endtask

  task automatic test_target_load();
    int          e0;
    int          lat;
    logic        p1;
    byte_t       model [tgt_addr_t];
    tgt_addr_t   ta_q [$];
    tgt_addr_t   ta;
    logic [13:0] woff;
    logic [1:0]  lane;
    logic [31:0] r;
    cpu_word_t   wdata;
    cpu_word_t   rd;
    byte_t       got;
    e0 = errors;
    for (int i = 0; i < N_LOAD; i++) begin
      r     = next_random();
      woff  = r[15:2];
      // first byte on lane 0, reused by the multi-byte write below
      lane  = (i == 0) ? 2'd0 : r[17:16];
      wdata = next_random();
      bus_access({`TGT_LOAD_HI, woff, 2'b00}, wdata, 4'b0001 << lane, rd, lat, p1);
      check_load_timing(lat, p1);
      ta = {woff, lane};
      if (!model.exists(ta)) begin
        ta_q.push_back(ta);
      end
      model[ta] = wdata[lane*8 +: 8];
    end
    // full-word strobe over the first loaded byte with different data
    ta    = ta_q[0];
    r     = next_random();
    wdata = {r[31:8], ~model[ta]};
    bus_access({`TGT_LOAD_HI, ta[15:2], 2'b00}, wdata, 4'b1111, rd, lat, p1);
    check_load_timing(lat, p1);
    foreach (ta_q[k]) begin
      read_target(ta_q[k], got);
      compare_byte(got, model[ta_q[k]], "target ram byte");
    end
    finish_test("target load", e0);
  endtask

  task automatic test_phase_reset();
    int          e0;
    int          n;
    int          lat;
    logic        p1;
    logic [31:0] r;
    cpu_word_t   rd;
    e0 = errors;
    wait_pulse(1'b0, n);
    wait_pulse(1'b1, n);
    compare_word(32'(n), 32'd4, "ph1 to ph2 spacing");
    wait_pulse(1'b0, n);
    compare_word(32'(n), 32'd4, "ph2 to ph1 spacing");
    wait_pulse(1'b0, n);
    compare_word(32'(n), 32'd8, "ph1 period");
    // target stopped and held in reset
    bus_access(`REG_EMU_CTRL, '0, 4'b1111, rd, lat, p1);
    wait_pulse(1'b1, n);
    @(negedge clk_8mhz);
    compare_bit(target_rst, 1'b1, "target reset while stopped");
    // start right after ph1 so the next ph2 follows the ack
    wait_pulse(1'b0, n);
    bus_access(`REG_EMU_CTRL, 32'h0000_0001, 4'b1111, rd, lat, p1);
    compare_word(32'(lat), 32'd1, "register write latency");
    wait_pulse(1'b1, n);
    compare_bit(target_rst, 1'b1, "target reset in the ph2 cycle");
    @(negedge clk_8mhz);
    compare_bit(target_rst, 1'b0, "target reset after ph2");
    r = next_random();
    bus_access(32'h5001_0000, r, 4'b1111, rd, lat, p1);
    compare_word(32'(lat), 32'd1, "other load region latency");
    finish_test("phase and target reset", e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    rst       = 1'b1;
    cpu_valid = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_wstrb = '0;
    tgt_addr  = '0;
    tgt_wdata = '0;
    tgt_we    = 1'b0;
    cont1_key = '0;
    cont2_key = '0;
    cont3_key = '0;
    cont4_key = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    rng_state = 32'h42ff_0b08;
    repeat (2) @(posedge clk_8mhz);
    rst <= 1'b0;
    test_reset();
    test_registers();
    test_work_ram();
    test_target_load();
    test_phase_reset();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles, the run did not finish",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- core_top.sv
/*
 * host control block top level
 * cpu bus responder, work ram, control registers, phase timer
 * and the target main ram load port
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module core_top import core_pkg::*; (
  input  wire            clk_8mhz,
  input  wire            rst,
  // cpu memory bus
  input  wire            i_cpu_valid,
  input  wire cpu_addr_t i_cpu_addr,
  input  wire cpu_word_t i_cpu_wdata,
  input  wire wstrb_t    i_cpu_wstrb,
  output wire            o_cpu_ready,
  output cpu_word_t      o_cpu_rdata,
  // target side of main ram
  input  wire tgt_addr_t i_tgt_addr,
  input  wire byte_t     i_tgt_wdata,
  input  wire            i_tgt_we,
  output byte_t          o_tgt_rdata,
  // controllers
  input  wire key_t      i_cont1_key,
  input  wire key_t      i_cont2_key,
  input  wire key_t      i_cont3_key,
  input  wire key_t      i_cont4_key,
  output joy_t           o_joy1,
  output joy_t           o_joy2,
  output wire [1:0]      o_osd_ctrl,
  output wire [63:0]     o_keyboard_mask,
  output wire            o_target_rst,
  output wire            o_ph1_en,
  output wire            o_ph2_en
);

  wstrb_t    ram_lane_we;
  wire       ram_ce;
  cpu_word_t ram_rdata;
  wire       reg_sel;
  cpu_word_t reg_rdata;
  wire       load_req;
  wire       load_done;
  wire [6:0] emu_ctrl;

  phase_timer u_phase_timer (
    .clk_8mhz    (clk_8mhz),
    .rst         (rst),
    .i_run       (emu_ctrl[0]),
    .o_ph1_en    (o_ph1_en),
    .o_ph2_en    (o_ph2_en),
    .o_target_rst(o_target_rst)
  );

  bus_responder u_bus_responder (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_cpu_valid  (i_cpu_valid),
    .i_cpu_addr   (i_cpu_addr),
    .i_cpu_wstrb  (i_cpu_wstrb),
    .i_ram_rdata  (ram_rdata),
    .i_reg_rdata  (reg_rdata),
    .i_load_done  (load_done),
    .o_ram_lane_we(ram_lane_we),
    .o_ram_ce     (ram_ce),
    .o_reg_sel    (reg_sel),
    .o_load_req   (load_req),
    .o_cpu_ready  (o_cpu_ready),
    .o_cpu_rdata  (o_cpu_rdata)
  );

  ctrl_regs u_ctrl_regs (
    .clk_8mhz       (clk_8mhz),
    .rst            (rst),
    .i_sel          (reg_sel),
    .i_addr         (i_cpu_addr),
    .i_wdata        (i_cpu_wdata),
    .i_wstrb        (i_cpu_wstrb),
    .i_cont1_key    (i_cont1_key),
    .i_cont2_key    (i_cont2_key),
    .i_cont3_key    (i_cont3_key),
    .i_cont4_key    (i_cont4_key),
    .o_rdata        (reg_rdata),
    .o_emu_ctrl     (emu_ctrl),
    .o_osd_ctrl     (o_osd_ctrl),
    .o_keyboard_mask(o_keyboard_mask),
    .o_joy1         (o_joy1),
    .o_joy2         (o_joy2)
  );

  load_port u_load_port (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .i_load_req (load_req),
    .i_addr     (i_cpu_addr),
    .i_wdata    (i_cpu_wdata),
    .i_wstrb    (i_cpu_wstrb),
    .i_ph1_en   (o_ph1_en),
    .i_ph2_en   (o_ph2_en),
    .i_tgt_addr (i_tgt_addr),
    .i_tgt_wdata(i_tgt_wdata),
    .i_tgt_we   (i_tgt_we),
    .o_tgt_rdata(o_tgt_rdata),
    .o_load_done(load_done)
  );

  //////////////////////////////////////////////////
  // work ram, one byte lane per instance
  //////////////////////////////////////////////////
  for (genvar gi = 0; gi < 4; gi++) begin : g_wram
    sp_ram #(
      .AW(`WORK_RAM_AW)
    ) u_lane (
      .clk_8mhz(clk_8mhz),
      .rst     (rst),
      .i_ce    (ram_ce),
      .i_we    (ram_lane_we[gi]),
      .i_addr  (i_cpu_addr[`WORK_RAM_AW+1:2]),
      .i_wdata (i_cpu_wdata[gi*8 +: 8]),
      .o_rdata (ram_rdata[gi*8 +: 8])
    );
  end

endmodule

`default_nettype wire

//--- load_port.sv
/*
 * target main ram load port
 * turns a single-byte cpu write into a ram write held for a whole ph2 window
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module load_port import core_pkg::*; (
  input  wire            clk_8mhz,
  input  wire            rst,
  input  wire            i_load_req,
  input  wire cpu_addr_t i_addr,
  input  wire cpu_word_t i_wdata,
  input  wire wstrb_t    i_wstrb,
  input  wire            i_ph1_en,
  input  wire            i_ph2_en,
  input  wire tgt_addr_t i_tgt_addr,
  input  wire byte_t     i_tgt_wdata,
  input  wire            i_tgt_we,
  output byte_t          o_tgt_rdata,
  output logic           o_load_done
);

  logic      lane_ok;
  logic [1:0] lane;
  byte_t     lane_byte;
  tgt_addr_t load_addr;
  logic      hold;
  logic      hold_we;
  tgt_addr_t hold_addr;
  byte_t     hold_data;

  // one-hot strobe only, anything else is a no-op write
  always_comb begin
    lane_ok = 1'b1;
    case (i_wstrb)
      4'b0001: lane = 2'd0;
      4'b0010: lane = 2'd1;
      4'b0100: lane = 2'd2;
      4'b1000: lane = 2'd3;
      default: begin
        lane    = 2'd0;
        lane_ok = 1'b0;
      end
    endcase
  end

  assign lane_byte = i_wdata[lane*8 +: 8];
  assign load_addr = {i_addr[`TGT_RAM_AW-1:2], lane};

  //////////////////////////////////////////////////
  // hold from ph2 to the following ph1
  //////////////////////////////////////////////////
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      hold    <= 1'b0;
      hold_we <= 1'b0;
    end else if (i_ph2_en && i_load_req) begin
      hold    <= 1'b1;
      hold_we <= lane_ok;
    end else if (i_ph1_en) begin
      hold    <= 1'b0;
      hold_we <= 1'b0;
    end
  end

  always_ff @(posedge clk_8mhz) begin
    if (i_ph2_en && i_load_req) begin
      hold_addr <= load_addr;
      hold_data <= lane_byte;
    end
  end

  assign o_load_done = hold && i_ph1_en;

  // load overrides the target port while held
  sp_ram #(
    .AW(`TGT_RAM_AW)
  ) u_main_ram (
    .clk_8mhz(clk_8mhz),
    .rst     (rst),
    .i_ce    (1'b1),
    .i_we    (hold ? hold_we : i_tgt_we),
    .i_addr  (hold ? hold_addr : i_tgt_addr),
    .i_wdata (hold ? hold_data : i_tgt_wdata),
    .o_rdata (o_tgt_rdata)
  );

endmodule

`default_nettype wire

//--- ctrl_regs.sv
/*
 * host control registers
 * emulator and osd control, keyboard mask, controller key readback
 * and the joystick source selection for both ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ctrl_regs import core_pkg::*; (
  input  wire            clk_8mhz,
  input  wire            rst,
  input  wire            i_sel,
  input  wire cpu_addr_t i_addr,
  input  wire cpu_word_t i_wdata,
  input  wire wstrb_t    i_wstrb,
  input  wire key_t      i_cont1_key,
  input  wire key_t      i_cont2_key,
  input  wire key_t      i_cont3_key,
  input  wire key_t      i_cont4_key,
  output cpu_word_t      o_rdata,
  output logic [6:0]     o_emu_ctrl,
  output logic [1:0]     o_osd_ctrl,
  output logic [63:0]    o_keyboard_mask,
  output joy_t           o_joy1,
  output joy_t           o_joy2
);

  logic wr_full;

  // 1 picks controller 1, 2 picks controller 2, else idle
  function automatic joy_t joy_pick(input logic [1:0] sel, input key_t k1, input key_t k2);
    joy_t joy;
    case (sel)
      2'b01:   joy = k1[6:0];
      2'b10:   joy = k2[6:0];
      default: joy = '0;
    endcase
    return joy;
  endfunction

  // partial writes are dropped
  assign wr_full = i_sel && (i_wstrb == 4'b1111);

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_emu_ctrl      <= '0;
      o_osd_ctrl      <= '0;
      o_keyboard_mask <= '0;
    end else if (wr_full) begin
      case (i_addr)
        `REG_EMU_CTRL:    o_emu_ctrl <= i_wdata[6:0];
        `REG_OSD_CTRL:    o_osd_ctrl <= i_wdata[1:0];
        `REG_KBD_MASK_LO: o_keyboard_mask[31:0] <= i_wdata;
        `REG_KBD_MASK_HI: o_keyboard_mask[63:32] <= i_wdata;
        default: ;
      endcase
    end
  end

  // readback, keys and emulator control only
  always_comb begin
    case (i_addr)
      `REG_CONT1_KEY: o_rdata = {16'h0000, i_cont1_key};
      `REG_CONT2_KEY: o_rdata = {16'h0000, i_cont2_key};
      `REG_CONT3_KEY: o_rdata = {16'h0000, i_cont3_key};
      `REG_CONT4_KEY: o_rdata = {16'h0000, i_cont4_key};
      `REG_EMU_CTRL:  o_rdata = {25'h0, o_emu_ctrl};
      default:        o_rdata = '0;
    endcase
  end

  assign o_joy1 = joy_pick(o_emu_ctrl[2:1], i_cont1_key, i_cont2_key);
  assign o_joy2 = joy_pick(o_emu_ctrl[4:3], i_cont1_key, i_cont2_key);

endmodule

`default_nettype wire

//--- bus_responder.sv
/*
 * cpu bus responder
 * decodes the address region, selects the target block,
 * muxes read data and times the one-cycle ready pulse
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module bus_responder import core_pkg::*; (
  input  wire         clk_8mhz,
  input  wire         rst,
  input  wire         i_cpu_valid,
  input  wire cpu_addr_t i_cpu_addr,
  input  wire wstrb_t i_cpu_wstrb,
  input  wire cpu_word_t i_ram_rdata,
  input  wire cpu_word_t i_reg_rdata,
  input  wire         i_load_done,
  output wstrb_t      o_ram_lane_we,
  output logic        o_ram_ce,
  output logic        o_reg_sel,
  output logic        o_load_req,
  output logic        o_cpu_ready,
  output cpu_word_t   o_cpu_rdata
);

  region_t     region;
  resp_state_t state;
  resp_state_t state_nxt;
  logic        access;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  always_comb begin
    case (i_cpu_addr[31:28])
      `REGION_WRAM_NIB: region = REGION_WRAM;
      `REGION_REGA_NIB, `REGION_REGB_NIB: region = REGION_REGS;
      `REGION_LOAD_NIB: begin
        // only 0x5000_xxxx reaches target ram
        if (i_cpu_addr[31:16] == `TGT_LOAD_HI) begin
          region = REGION_TGT_LOAD;
        end else begin
          region = REGION_OTHER_LOAD;
        end
      end
      default: region = REGION_UNMAPPED;
    endcase
  end

  //////////////////////////////////////////////////
  // handshake fsm
  //////////////////////////////////////////////////
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      state <= RESP_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      RESP_IDLE: begin
        if (i_cpu_valid) begin
          case (region)
            REGION_WRAM, REGION_REGS, REGION_OTHER_LOAD: state_nxt = RESP_ACK;
            REGION_TGT_LOAD: state_nxt = RESP_WAIT;
            // unmapped, never answered
            default: state_nxt = RESP_IDLE;
          endcase
        end
      end
      RESP_WAIT: begin
        if (i_load_done) begin
          state_nxt = RESP_ACK;
        end
      end
      default: state_nxt = RESP_IDLE;
    endcase
  end

  // first cycle of an access, targets act only here
  assign access = (state == RESP_IDLE) && i_cpu_valid;

  assign o_ram_ce      = access && (region == REGION_WRAM);
  assign o_ram_lane_we = o_ram_ce ? i_cpu_wstrb : 4'b0000;
  assign o_reg_sel     = access && (region == REGION_REGS);
  // held until the load port reports its ph1
  assign o_load_req    = i_cpu_valid && (region == REGION_TGT_LOAD) && (state != RESP_ACK);
  assign o_cpu_ready   = (state == RESP_ACK);

  // load regions read back as zero
  always_comb begin
    case (region)
      REGION_WRAM: o_cpu_rdata = i_ram_rdata;
      REGION_REGS: o_cpu_rdata = i_reg_rdata;
      default:     o_cpu_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- phase_timer.sv
/*
 * 1 MHz two-phase enable generator
 * also holds the target reset, released only on a phase-2 edge
 */

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module phase_timer (
  input  wire  clk_8mhz,
  input  wire  rst,
  input  wire  i_run,
  output logic o_ph1_en,
  output logic o_ph2_en,
  output logic o_target_rst
);

  localparam logic [`PH_CNT_W-1:0] PH1_CNT = `PH1_COUNT;
  localparam logic [`PH_CNT_W-1:0] PH2_CNT = `PH2_COUNT;

  logic [`PH_CNT_W-1:0] ph_cnt;

  // free running, zero right after reset so ph1 comes first
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      ph_cnt <= '0;
    end else begin
      ph_cnt <= ph_cnt + 1'b1;
    end
  end

  assign o_ph1_en = (ph_cnt == PH1_CNT);
  assign o_ph2_en = (ph_cnt == PH2_CNT);

  // change only on ph2 so the target always wakes up on ph1
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_target_rst <= 1'b1;
    end else if (o_ph2_en) begin
      o_target_rst <= ~i_run;
    end
  end

endmodule

`default_nettype wire

//--- sp_ram.sv
/*
 * single-port byte ram, registered read
 */

`timescale 1ns/1ps
`default_nettype none

module sp_ram import core_pkg::*; #(
  parameter int AW = 10
) (
  input  wire          clk_8mhz,
  input  wire          rst,
  input  wire          i_ce,
  input  wire          i_we,
  input  wire [AW-1:0] i_addr,
  input  wire byte_t   i_wdata,
  output byte_t        o_rdata
);

  byte_t mem [0:(2**AW)-1];

  always_ff @(posedge clk_8mhz) begin
    if (i_ce && i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // old contents come out on a write cycle
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_rdata <= '0;
    end else if (i_ce) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

`default_nettype wire

//--- core_pkg.sv
/*
 * shared types of the host control block
 * cpu bus, byte lanes, controller keys and decoder states
 */

`default_nettype none

`include "core_defs.svh"

package core_pkg;

  // cpu bus side
  typedef logic [31:0] cpu_addr_t;
  typedef logic [31:0] cpu_word_t;
  typedef logic [3:0]  wstrb_t;
  typedef logic [7:0]  byte_t;

  // controller keys, joystick is the low 7 key bits
  typedef logic [15:0] key_t;
  typedef logic [6:0]  joy_t;

  typedef logic [`TGT_RAM_AW-1:0] tgt_addr_t;

  typedef enum logic [2:0] {
    REGION_WRAM,
    REGION_REGS,
    REGION_TGT_LOAD,
    REGION_OTHER_LOAD,
    REGION_UNMAPPED
  } region_t;

  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_WAIT,
    RESP_ACK
  } resp_state_t;

endpackage

`default_nettype wire

//--- core_defs.svh
/*
 * host control block constants
 * address decode codes, register map, memory depths and phase counter
 */

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

//////////////////////////////////////////////////
// region codes, top nibble of the cpu address
//////////////////////////////////////////////////
`define REGION_WRAM_NIB   4'h1
`define REGION_REGA_NIB   4'h2
`define REGION_REGB_NIB   4'h3
`define REGION_LOAD_NIB   4'h5

// upper half of the target main ram load window
`define TGT_LOAD_HI       16'h5000

//////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////
`define REG_CONT1_KEY     32'h2000_0000
`define REG_CONT2_KEY     32'h2000_0004
`define REG_CONT3_KEY     32'h2000_0008
`define REG_CONT4_KEY     32'h2000_000c
`define REG_OSD_CTRL      32'h3000_0000
`define REG_KBD_MASK_LO   32'h3000_0004
`define REG_KBD_MASK_HI   32'h3000_0008
`define REG_EMU_CTRL      32'h3000_000c

// memory depths as address widths
`define WORK_RAM_AW       10
`define TGT_RAM_AW        16

// 1 MHz phases out of the 8 MHz clock
`define PH_CNT_W          3
`define PH1_COUNT         0
`define PH2_COUNT         4

`endif
